/* hw/cpu_pkg.sv */
package cpu_pkg;

    localparam int data_bits  = 32;
    localparam int regno_bits = 4;
    localparam int reg_count  = 1 << regno_bits;

    typedef logic [data_bits-1:0]  word_t;
    typedef logic [regno_bits-1:0] regno_t;
    typedef logic [5:0]            op1_t;
    typedef logic [7:0]            op2_t;
    typedef logic [1:0]            wb_src_t;

    // Primary opcodes
    localparam op1_t op1_alur = 6'b000000;
    localparam op1_t op1_beq  = 6'b001000;
    localparam op1_t op1_blt  = 6'b001001;
    localparam op1_t op1_ble  = 6'b001010;
    localparam op1_t op1_bne  = 6'b001011;
    localparam op1_t op1_jal  = 6'b001100;
    localparam op1_t op1_lw   = 6'b010010;
    localparam op1_t op1_sw   = 6'b011010;
    localparam op1_t op1_addi = 6'b100000;
    localparam op1_t op1_andi = 6'b100100;
    localparam op1_t op1_ori  = 6'b100101;
    localparam op1_t op1_xori = 6'b100110;

    // Secondary opcodes under op1_alur
    localparam op2_t op2_eq   = 8'b00001000;
    localparam op2_t op2_lt   = 8'b00001001;
    localparam op2_t op2_le   = 8'b00001010;
    localparam op2_t op2_ne   = 8'b00001011;
    localparam op2_t op2_add  = 8'b00100000;
    localparam op2_t op2_and  = 8'b00100100;
    localparam op2_t op2_or   = 8'b00100101;
    localparam op2_t op2_xor  = 8'b00100110;
    localparam op2_t op2_sub  = 8'b00101000;
    localparam op2_t op2_nand = 8'b00101100;
    localparam op2_t op2_nor  = 8'b00101101;
    localparam op2_t op2_nxor = 8'b00101110;
    localparam op2_t op2_rshf = 8'b00110000;
    localparam op2_t op2_lshf = 8'b00110001;

    // Instruction fields, imm overlaps op2 and rd
    localparam int op1_msb = 31;
    localparam int op1_lsb = 26;
    localparam int op2_msb = 25;
    localparam int op2_lsb = 18;
    localparam int imm_msb = 23;
    localparam int imm_lsb = 8;
    localparam int rd_msb  = 11;
    localparam int rd_lsb  = 8;
    localparam int rs_msb  = 7;
    localparam int rs_lsb  = 4;
    localparam int rt_msb  = 3;
    localparam int rt_lsb  = 0;
    localparam int imm_bits = imm_msb - imm_lsb + 1;

    localparam word_t inst_size = 32'd4;
    localparam word_t start_pc  = 32'h100;

    localparam int imem_addr_bits = 16;
    localparam int dmem_addr_bits = 16;
    localparam int word_bits      = 2;   // Byte offset within a word
    localparam int imem_words     = 1 << (imem_addr_bits - word_bits);
    localparam int dmem_words     = 1 << (dmem_addr_bits - word_bits);

    // Memory-mapped I/O
    localparam word_t addr_hex  = 32'hFFFFF000;
    localparam word_t addr_ledr = 32'hFFFFF020;
    localparam word_t addr_key  = 32'hFFFFF080;
    localparam int hex_bits  = 24;
    localparam int ledr_bits = 10;
    localparam int key_bits  = 4;
    localparam logic [hex_bits-1:0] hex_reset = 24'hFEDEAD;

    // Writeback source
    localparam wb_src_t wb_ret = 2'd0;
    localparam wb_src_t wb_mem = 2'd1;
    localparam wb_src_t wb_alu = 2'd2;

    function automatic word_t sext_imm(word_t inst);
        return {{(data_bits - imm_bits){inst[imm_msb]}}, inst[imm_msb:imm_lsb]};
    endfunction

    function automatic logic is_branch_op(op1_t op);
        return op == op1_beq || op == op1_blt || op == op1_ble || op == op1_bne;
    endfunction

endpackage

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    input  logic           jal_redirect,
    input  cpu_pkg::word_t jal_target,
    input  logic           mispredict,
    output cpu_pkg::word_t inst,
    output cpu_pkg::word_t pc_next,
    output logic           fe_valid
);

    cpu_pkg::word_t imem [cpu_pkg::imem_words];
    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_plus;
    cpu_pkg::word_t inst_w;
    cpu_pkg::word_t pred_target;
    cpu_pkg::word_t fall_through;   // Belongs to the instruction now in execute
    logic           predict_taken;

    initial begin
        $readmemh("program.hex", imem);
    end

    assign inst_w        = imem[pc[cpu_pkg::imem_addr_bits-1:cpu_pkg::word_bits]];
    assign pc_plus       = pc + cpu_pkg::inst_size;
    assign pred_target   = pc_plus + (cpu_pkg::sext_imm(inst_w) << 2);
    assign predict_taken = cpu_pkg::is_branch_op(inst_w[cpu_pkg::op1_msb:cpu_pkg::op1_lsb]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= cpu_pkg::start_pc;
        end else if (mispredict) begin
            pc <= fall_through;
        end else if (jal_redirect) begin
            pc <= jal_target;
        end else if (!stall) begin
            pc <= predict_taken ? pred_target : pc_plus;  // Always taken
        end
    end

    // Follows the fetch latch into the decode latch one cycle later
    always_ff @(posedge clk) begin
        fall_through <= pc_next;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fe_valid <= 1'b0;
        end else if (mispredict || jal_redirect) begin
            fe_valid <= 1'b0;   // Wrong-path word dropped
        end else if (!stall) begin
            fe_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mispredict || jal_redirect || !stall) begin
            inst    <= inst_w;
            pc_next <= pc_plus;
        end
    end

    // Predicted targets and redirects stay word aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset) pc[cpu_pkg::word_bits-1:0] == '0
    );

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::word_t   inst,
    input  cpu_pkg::word_t   pc_next,
    input  logic             fe_valid,
    input  cpu_pkg::regno_t  ex_dst,
    input  logic             ex_we,
    input  cpu_pkg::regno_t  mem_dst,
    input  logic             mem_we_reg,
    input  logic             wb_we,
    input  cpu_pkg::regno_t  wb_reg,
    input  cpu_pkg::word_t   wb_data,
    input  logic             mispredict,
    output cpu_pkg::word_t   rs_val,
    output cpu_pkg::word_t   rt_val,
    output cpu_pkg::word_t   imm_sx,
    output cpu_pkg::op1_t    op1,
    output cpu_pkg::op2_t    op2,
    output logic             use_imm,
    output logic             is_branch,
    output logic             mem_we,
    output logic             mem_re,
    output logic             reg_we,
    output cpu_pkg::wb_src_t wb_src,
    output cpu_pkg::regno_t  dst_reg,
    output cpu_pkg::word_t   ret_addr,
    output logic             stall,
    output logic             jal_redirect,
    output cpu_pkg::word_t   jal_target
);

    cpu_pkg::word_t  regs [cpu_pkg::reg_count];
    cpu_pkg::op1_t   op1_w;
    cpu_pkg::regno_t rd_w;
    cpu_pkg::regno_t rs_w;
    cpu_pkg::regno_t rt_w;
    cpu_pkg::word_t  rs_val_w;
    cpu_pkg::word_t  imm_w;
    logic is_alur;
    logic is_br;
    logic is_jal;
    logic is_lw;
    logic is_sw;
    logic is_alui;
    logic reads_rt;
    logic rs_busy;
    logic rt_busy;
    logic hazard;
    logic valid;

    assign op1_w = inst[cpu_pkg::op1_msb:cpu_pkg::op1_lsb];
    assign rd_w  = inst[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
    assign rs_w  = inst[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
    assign rt_w  = inst[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
    assign imm_w = cpu_pkg::sext_imm(inst);

    assign is_alur = op1_w == cpu_pkg::op1_alur;
    assign is_br   = cpu_pkg::is_branch_op(op1_w);
    assign is_jal  = op1_w == cpu_pkg::op1_jal;
    assign is_lw   = op1_w == cpu_pkg::op1_lw;
    assign is_sw   = op1_w == cpu_pkg::op1_sw;
    assign is_alui = op1_w == cpu_pkg::op1_addi || op1_w == cpu_pkg::op1_andi ||
                     op1_w == cpu_pkg::op1_ori  || op1_w == cpu_pkg::op1_xori;

    // Every format reads rs, only these read rt
    assign reads_rt = is_alur || is_br || is_sw;

    // No forwarding, so wait while a producer sits in execute or memory
    assign rs_busy = (ex_we && ex_dst == rs_w) || (mem_we_reg && mem_dst == rs_w);
    assign rt_busy = (ex_we && ex_dst == rt_w) || (mem_we_reg && mem_dst == rt_w);
    assign hazard  = fe_valid && (rs_busy || (reads_rt && rt_busy));

    assign stall        = hazard && !mispredict;
    assign valid        = fe_valid && !hazard && !mispredict;
    assign rs_val_w     = regs[rs_w];
    assign jal_redirect = valid && is_jal;
    assign jal_target   = rs_val_w + (imm_w << 2);

    // Written mid-cycle so decode sees the value in the same cycle
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_reg] <= wb_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            is_branch <= 1'b0;
            mem_we    <= 1'b0;
            mem_re    <= 1'b0;
            reg_we    <= 1'b0;
        end else begin
            is_branch <= valid && is_br;   // Bubble on stall or flush
            mem_we    <= valid && is_sw;
            mem_re    <= valid && is_lw;
            reg_we    <= valid && (is_alur || is_jal || is_lw || is_alui);
        end
    end

    always_ff @(posedge clk) begin
        rs_val   <= rs_val_w;
        rt_val   <= regs[rt_w];
        imm_sx   <= imm_w;
        op1      <= op1_w;
        op2      <= inst[cpu_pkg::op2_msb:cpu_pkg::op2_lsb];
        use_imm  <= is_lw || is_sw || is_alui;
        dst_reg  <= is_alur ? rd_w : rt_w;
        ret_addr <= pc_next;
        if (is_jal) begin
            wb_src <= cpu_pkg::wb_ret;
        end else if (is_lw) begin
            wb_src <= cpu_pkg::wb_mem;
        end else begin
            wb_src <= cpu_pkg::wb_alu;
        end
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::word_t   rs_val,
    input  cpu_pkg::word_t   rt_val,
    input  cpu_pkg::word_t   imm_sx,
    input  cpu_pkg::op1_t    op1,
    input  cpu_pkg::op2_t    op2,
    input  logic             use_imm,
    input  logic             is_branch,
    input  logic             mem_we,
    input  logic             mem_re,
    input  logic             reg_we,
    input  cpu_pkg::wb_src_t wb_src,
    input  cpu_pkg::regno_t  dst_reg,
    input  cpu_pkg::word_t   ret_addr,
    output logic             mispredict,
    output cpu_pkg::regno_t  ex_dst,
    output logic             ex_we,
    output cpu_pkg::word_t   alu_out,
    output cpu_pkg::word_t   store_data,
    output logic             m_mem_we,
    output logic             m_mem_re,
    output logic             m_reg_we,
    output cpu_pkg::wb_src_t m_wb_src,
    output cpu_pkg::regno_t  m_dst_reg,
    output cpu_pkg::word_t   m_ret_addr
);

    logic signed [cpu_pkg::data_bits-1:0] a;
    logic signed [cpu_pkg::data_bits-1:0] b;
    logic signed [cpu_pkg::data_bits-1:0] result;
    logic taken;

    assign a = rs_val;
    assign b = use_imm ? imm_sx : rt_val;   // rt for branches

    always_comb begin
        result = '0;
        case (op1)
            cpu_pkg::op1_alur: begin
                case (op2)
                    cpu_pkg::op2_eq:   result = cpu_pkg::word_t'(a == b);
                    cpu_pkg::op2_lt:   result = cpu_pkg::word_t'(a < b);
                    cpu_pkg::op2_le:   result = cpu_pkg::word_t'(a <= b);
                    cpu_pkg::op2_ne:   result = cpu_pkg::word_t'(a != b);
                    cpu_pkg::op2_add:  result = a + b;
                    cpu_pkg::op2_and:  result = a & b;
                    cpu_pkg::op2_or:   result = a | b;
                    cpu_pkg::op2_xor:  result = a ^ b;
                    cpu_pkg::op2_sub:  result = a - b;
                    cpu_pkg::op2_nand: result = ~(a & b);
                    cpu_pkg::op2_nor:  result = ~(a | b);
                    cpu_pkg::op2_nxor: result = ~(a ^ b);
                    cpu_pkg::op2_rshf: result = a >>> b;   // Arithmetic
                    cpu_pkg::op2_lshf: result = a <<< b;
                    default:           result = '0;
                endcase
            end
            cpu_pkg::op1_lw,
            cpu_pkg::op1_sw,
            cpu_pkg::op1_addi: result = a + b;   // Also the load/store address
            cpu_pkg::op1_andi: result = a & b;
            cpu_pkg::op1_ori:  result = a | b;
            cpu_pkg::op1_xori: result = a ^ b;
            default:           result = '0;
        endcase
    end

    always_comb begin
        case (op1)
            cpu_pkg::op1_beq: taken = a == b;
            cpu_pkg::op1_blt: taken = a < b;
            cpu_pkg::op1_ble: taken = a <= b;
            cpu_pkg::op1_bne: taken = a != b;
            default:          taken = 1'b0;
        endcase
    end

    // Fetch predicted taken, so only a false condition redirects
    assign mispredict = is_branch && !taken;
    assign ex_dst     = dst_reg;
    assign ex_we      = reg_we;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m_mem_we <= 1'b0;
            m_mem_re <= 1'b0;
            m_reg_we <= 1'b0;
        end else begin
            m_mem_we <= mem_we && !mispredict;
            m_mem_re <= mem_re && !mispredict;
            m_reg_we <= reg_we && !mispredict;
        end
    end

    always_ff @(posedge clk) begin
        alu_out    <= result;
        store_data <= rt_val;
        m_wb_src   <= wb_src;
        m_dst_reg  <= dst_reg;
        m_ret_addr <= ret_addr;
    end

    // Only a decoded branch opcode may resolve as not taken
    a_mispredict_branch: assert property (
        @(posedge clk) disable iff (reset) mispredict |-> cpu_pkg::is_branch_op(op1)
    );

    // The flushed decode latch must deliver a bubble right behind the branch
    a_flush_bubble: assert property (
        @(posedge clk) disable iff (reset)
        mispredict |=> !(is_branch || reg_we || mem_we || mem_re)
    );

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [cpu_pkg::key_bits-1:0]  key,
    input  cpu_pkg::word_t                alu_out,
    input  cpu_pkg::word_t                store_data,
    input  logic                          mem_we,
    input  logic                          mem_re,
    input  logic                          reg_we,
    input  cpu_pkg::wb_src_t              wb_src,
    input  cpu_pkg::regno_t               dst_reg,
    input  cpu_pkg::word_t                ret_addr,
    output logic [cpu_pkg::hex_bits-1:0]  hex,
    output logic [cpu_pkg::ledr_bits-1:0] ledr,
    output cpu_pkg::regno_t               mem_dst,
    output logic                          mem_we_reg,
    output logic                          wb_we,
    output cpu_pkg::regno_t               wb_reg,
    output cpu_pkg::word_t                wb_data
);

    cpu_pkg::word_t dmem [cpu_pkg::dmem_words];
    cpu_pkg::word_t load_data;
    cpu_pkg::word_t result;
    logic sel_hex;
    logic sel_ledr;
    logic sel_key;
    logic sel_dmem;

    assign sel_hex  = alu_out == cpu_pkg::addr_hex;
    assign sel_ledr = alu_out == cpu_pkg::addr_ledr;
    assign sel_key  = alu_out == cpu_pkg::addr_key;
    assign sel_dmem = !(sel_hex || sel_ledr || sel_key);

    // Keys are active low
    assign load_data = !mem_re ? '0 :
                       sel_key ? {{(cpu_pkg::data_bits - cpu_pkg::key_bits){1'b0}}, ~key} :
                       dmem[alu_out[cpu_pkg::dmem_addr_bits-1:cpu_pkg::word_bits]];

    assign mem_dst    = dst_reg;
    assign mem_we_reg = reg_we;

    always_ff @(posedge clk) begin
        if (mem_we && sel_dmem) begin
            dmem[alu_out[cpu_pkg::dmem_addr_bits-1:cpu_pkg::word_bits]] <= store_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hex  <= cpu_pkg::hex_reset;
            ledr <= '0;
        end else if (mem_we) begin
            if (sel_hex) hex <= store_data[cpu_pkg::hex_bits-1:0];
            if (sel_ledr) ledr <= store_data[cpu_pkg::ledr_bits-1:0];
        end
    end

    always_comb begin
        case (wb_src)
            cpu_pkg::wb_ret: result = ret_addr;
            cpu_pkg::wb_mem: result = load_data;
            default:         result = alu_out;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= reg_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= dst_reg;
        wb_data <= result;
    end

    // Decode never flags one instruction as both load and store
    a_store_load_excl: assert property (
        @(posedge clk) disable iff (reset) !(mem_we && mem_re)
    );

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [cpu_pkg::key_bits-1:0]  key,
    output logic [cpu_pkg::hex_bits-1:0]  hex,
    output logic [cpu_pkg::ledr_bits-1:0] ledr
);

    // Fetch and decode
    cpu_pkg::word_t   inst;
    cpu_pkg::word_t   pc_next;
    logic             fe_valid;
    logic             stall;
    logic             jal_redirect;
    cpu_pkg::word_t   jal_target;

    // Decode to execute
    cpu_pkg::word_t   rs_val;
    cpu_pkg::word_t   rt_val;
    cpu_pkg::word_t   imm_sx;
    cpu_pkg::op1_t    op1;
    cpu_pkg::op2_t    op2;
    logic             use_imm;
    logic             is_branch;
    logic             mem_we;
    logic             mem_re;
    logic             reg_we;
    cpu_pkg::wb_src_t wb_src;
    cpu_pkg::regno_t  dst_reg;
    cpu_pkg::word_t   ret_addr;

    // Execute to memory and hazard feedback
    logic             mispredict;
    cpu_pkg::regno_t  ex_dst;
    logic             ex_we;
    cpu_pkg::word_t   alu_out;
    cpu_pkg::word_t   store_data;
    logic             m_mem_we;
    logic             m_mem_re;
    logic             m_reg_we;
    cpu_pkg::wb_src_t m_wb_src;
    cpu_pkg::regno_t  m_dst_reg;
    cpu_pkg::word_t   m_ret_addr;

    // Writeback
    cpu_pkg::regno_t  mem_dst;
    logic             mem_we_reg;
    logic             wb_we;
    cpu_pkg::regno_t  wb_reg;
    cpu_pkg::word_t   wb_data;

    fetch_stage u_fetch (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .jal_redirect (jal_redirect),
        .jal_target   (jal_target),
        .mispredict   (mispredict),
        .inst         (inst),
        .pc_next      (pc_next),
        .fe_valid     (fe_valid)
    );

    decode_stage u_decode (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .pc_next      (pc_next),
        .fe_valid     (fe_valid),
        .ex_dst       (ex_dst),
        .ex_we        (ex_we),
        .mem_dst      (mem_dst),
        .mem_we_reg   (mem_we_reg),
        .wb_we        (wb_we),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .mispredict   (mispredict),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .imm_sx       (imm_sx),
        .op1          (op1),
        .op2          (op2),
        .use_imm      (use_imm),
        .is_branch    (is_branch),
        .mem_we       (mem_we),
        .mem_re       (mem_re),
        .reg_we       (reg_we),
        .wb_src       (wb_src),
        .dst_reg      (dst_reg),
        .ret_addr     (ret_addr),
        .stall        (stall),
        .jal_redirect (jal_redirect),
        .jal_target   (jal_target)
    );

    execute_stage u_execute (
        .clk        (clk),
        .reset      (reset),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .imm_sx     (imm_sx),
        .op1        (op1),
        .op2        (op2),
        .use_imm    (use_imm),
        .is_branch  (is_branch),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .reg_we     (reg_we),
        .wb_src     (wb_src),
        .dst_reg    (dst_reg),
        .ret_addr   (ret_addr),
        .mispredict (mispredict),
        .ex_dst     (ex_dst),
        .ex_we      (ex_we),
        .alu_out    (alu_out),
        .store_data (store_data),
        .m_mem_we   (m_mem_we),
        .m_mem_re   (m_mem_re),
        .m_reg_we   (m_reg_we),
        .m_wb_src   (m_wb_src),
        .m_dst_reg  (m_dst_reg),
        .m_ret_addr (m_ret_addr)
    );

    memory_stage u_memory (
        .clk        (clk),
        .reset      (reset),
        .key        (key),
        .alu_out    (alu_out),
        .store_data (store_data),
        .mem_we     (m_mem_we),
        .mem_re     (m_mem_re),
        .reg_we     (m_reg_we),
        .wb_src     (m_wb_src),
        .dst_reg    (m_dst_reg),
        .ret_addr   (m_ret_addr),
        .hex        (hex),
        .ledr       (ledr),
        .mem_dst    (mem_dst),
        .mem_we_reg (mem_we_reg),
        .wb_we      (wb_we),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    input  logic restart,
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // Reset for 16 cycles at start and again after each restart request
    initial begin
        reset = 1'b1;
        forever begin
            repeat (16) @(posedge clk);
            #1 reset = 1'b0;
            @(posedge restart);
            reset = 1'b1;
        end
    end

endmodule

/* test/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    localparam int num_random      = 24;
    localparam int num_tests       = 16 + num_random + 2;   // Sweep, random keys, two resets
    localparam int watchdog_cycles = num_tests * 2000;
    localparam int advance_limit   = 2000;   // Longest gap allowed between LEDR writes
    localparam logic [23:0] hex_after_reset = 24'hFEDEAD;

    logic        clk;
    logic        reset;
    logic        restart;
    logic [3:0]  key;
    logic [23:0] hex;
    logic [9:0]  ledr;

    integer      seed;
    int          error_count = 0;
    int          advances = 0;   // LEDR changes seen so far
    int          exp_count;      // Count field expected in the next LEDR write
    logic [9:0]  last_ledr;
    logic [3:0]  cur_k;          // Inverted key now on the pins
    logic [3:0]  prev_k;         // An iteration in flight may still have read this one

    clock_gen u_clock (
        .restart (restart),
        .clk     (clk),
        .reset   (reset)
    );

    cpu_top DUT (
        .clk   (clk),
        .reset (reset),
        .key   (key),
        .hex   (hex),
        .ledr  (ledr)
    );

    // Expected {hex, ledr} for one loop iteration of the program
    function automatic logic [33:0] model_outputs(input logic [3:0] k, input int count);
        int          s;
        logic [23:0] h;
        logic [9:0]  l;
        s = 0;
        for (int i = 1; i <= int'(k); i++) begin
            s = s + i;
        end
        h = 24'(((s << 4) ^ 32'h5A) - int'(k));
        l = 10'(((count % 64) << 4) | int'(k));
        return {h, l};
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Key is active low on the pins
    task automatic apply_key(input logic [3:0] k);
        @(posedge clk);
        #1;
        prev_k = cur_k;
        cur_k  = k;
        key    = ~k;
    endtask

    task automatic wait_advances(input int n);
        int target;
        int cycles;
        target = advances + n;
        cycles = 0;
        while (advances < target && cycles <= advance_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (advances < target) begin
            $display("LEDR stopped changing, no new write within %0d cycles", advance_limit);
            $display("Result: FAILED");
            $fatal(1, "program stalled");
        end
    endtask

    task automatic expect_reset_state();
        check_value("hex after reset", 32'(hex), 32'(hex_after_reset));
        check_value("ledr after reset", 32'(ledr), 32'd0);
    endtask

    // Latest iteration must have read the new key
    task automatic expect_key_result();
        logic [33:0] expected;
        @(negedge clk);
        expected = model_outputs(cur_k, 0);
        check_value("ledr key field", 32'(ledr[3:0]), 32'(cur_k));
        check_value("hex for key", 32'(hex), 32'(expected[33:10]));
    endtask

    task automatic expect_count_restart();
        wait_advances(1);
        @(negedge clk);
        check_value("count field, first write", 32'(ledr[9:4]), 32'd0);
        wait_advances(1);
        @(negedge clk);
        check_value("count field, second write", 32'(ledr[9:4]), 32'd1);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        #1 restart = 1'b1;
        @(posedge clk);
        #1 restart = 1'b0;
        @(negedge clk);
        expect_reset_state();   // Reset still held
        @(negedge reset);
        @(negedge clk);
        expect_reset_state();
    endtask

    // Every LEDR change is one loop iteration
    always @(negedge clk) begin : compare_outputs
        logic [3:0]  k_used;
        logic [33:0] expected;
        if (reset) begin
            exp_count = 0;
            last_ledr = '0;
        end else if (ledr !== last_ledr) begin
            k_used   = (ledr[3:0] == cur_k) ? cur_k : prev_k;
            expected = model_outputs(k_used, exp_count);
            check_value("hex at LEDR write", 32'(hex), 32'(expected[33:10]));
            check_value("ledr", 32'(ledr), 32'(expected[9:0]));
            last_ledr = ledr;
            exp_count = exp_count + 1;
            advances  = advances + 1;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, test sequence did not finish",
                 watchdog_cycles);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] rnd;
        seed    = 47324;
        restart = 1'b0;
        cur_k   = 4'd5;   // Nonzero so the first write changes LEDR
        prev_k  = 4'd5;
        key     = ~4'd5;

        repeat (8) @(negedge clk);
        expect_reset_state();
        @(negedge reset);
        @(negedge clk);
        expect_reset_state();
        expect_count_restart();

        for (int k = 0; k < 16; k++) begin
            apply_key(4'(k));
            wait_advances(2);
            expect_key_result();
        end

        for (int n = 0; n < num_random; n++) begin
            rnd = $random(seed);
            apply_key(rnd[3:0]);
            wait_advances(2);
            expect_key_result();
        end

        // Mid-run reset, the old key is gone with the flushed pipeline
        apply_key(4'd9);
        prev_k = cur_k;
        pulse_reset();
        expect_count_restart();
        expect_key_result();

        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* program.hex */
// One instruction word per line, loaded at word 0x40 (byte address 0x100)
// Main loop at 0x108, sum subroutine at 0x140
@40
80000004  // 100 addi r4 = r0 + 0, count
80000405  // 104 addi r5 = r0 + 4, shift amount
48F08001  // 108 lw   r1 = KEY, k
3000500E  // 10C jal  r14, 0x140
68002002  // 110 sw   r2 -> dmem 0x20
48002007  // 114 lw   r7 <- dmem 0x20
00C40875  // 118 lshf r8 = r7 << r5
98005A88  // 11C xori r8 = r8 ^ 0x5A
00A00881  // 120 sub  r8 = r8 - r1
68F00008  // 124 sw   r8 -> HEX
90003F49  // 128 andi r9 = r4 & 63
00C40995  // 12C lshf r9 = r9 << r5
00940991  // 130 or   r9 = r9 | r1
68F02009  // 134 sw   r9 -> LEDR
80000144  // 138 addi r4 = r4 + 1
20FFF200  // 13C beq  r0, r0, 0x108
80000002  // 140 addi r2 = r0 + 0, sum
80000003  // 144 addi r3 = r0 + 0, i
20000310  // 148 beq  r1, r0, 0x158
80000133  // 14C addi r3 = r3 + 1
00800223  // 150 add  r2 = r2 + r3
24FFFD31  // 154 blt  r3, r1, 0x14C
300000EF  // 158 jal  r15, 0(r14), return

/* verilog.f */
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
test/clock_gen.sv
test/tb_cpu.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_cpu
FILELIST := verilog.f
OBJDIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
